// File: hw/glb_bank.sv
//////////////////////////////////////////////////////////////////////
// one tile's memory bank, byte strobe writes, registered read
//////////////////////////////////////////////////////////////////////
module glb_bank
    import glb_const_pkg::*;
(
    input  logic            clk,

    input  logic            wr_en,
    input  bank_strb_t      wr_strb,
    input  bank_word_addr_t wr_addr,
    input  bank_data_t      wr_data,

    input  logic            rd_en,
    input  bank_word_addr_t rd_addr,
    output bank_data_t      rd_data
);

    bank_data_t mem [BANK_DEPTH];

    // only bytes with their strobe set are written
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wr_strb[b]) begin
                    mem[wr_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <= wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // data shows up the cycle after rd_en and then holds
    // a read hitting a word being written returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/glb_const_pkg.sv
//////////////////////////////////////////////////////////////////////
// global buffer sizes, address fields and register indices
// plus the vector types for widths that carry a meaning
//////////////////////////////////////////////////////////////////////
package glb_const_pkg;

    // tiles
    localparam int NUM_GLB_TILES       = 4;
    localparam int TILE_SEL_ADDR_WIDTH = 2;

    // processor port, top bits pick the tile
    localparam int GLB_ADDR_WIDTH       = 12;
    localparam int BANK_DATA_WIDTH      = 64;
    localparam int BYTE_WIDTH           = 8;
    localparam int BANK_STRB_WIDTH      = BANK_DATA_WIDTH / BYTE_WIDTH;
    localparam int BANK_DEPTH           = 128;
    localparam int BANK_WORD_ADDR_WIDTH = 7;
    localparam int BANK_BYTE_OFFSET     = $clog2(BANK_STRB_WIDTH);

    // configuration port
    localparam int AXI_ADDR_WIDTH    = 8;
    localparam int AXI_DATA_WIDTH    = 32;
    localparam int CFG_REG_SEL_LSB   = 2;
    localparam int CFG_REG_SEL_WIDTH = 2;

    // register map of one tile
    localparam logic [CFG_REG_SEL_WIDTH-1:0] CFG_REG_CTRL    = 2'd0;
    localparam logic [CFG_REG_SEL_WIDTH-1:0] CFG_REG_TILE_ID = 2'd1;
    localparam int                           CTRL_WR_LOCK_BIT = 0;

    typedef logic [GLB_ADDR_WIDTH-1:0]       glb_addr_t;
    typedef logic [BANK_DATA_WIDTH-1:0]      bank_data_t;
    typedef logic [BANK_STRB_WIDTH-1:0]      bank_strb_t;
    typedef logic [BANK_WORD_ADDR_WIDTH-1:0] bank_word_addr_t;
    typedef logic [TILE_SEL_ADDR_WIDTH-1:0]  tile_id_t;
    typedef logic [AXI_ADDR_WIDTH-1:0]       cfg_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0]       cfg_data_t;

endpackage

// File: hw/glb_packet_pkg.sv
//////////////////////////////////////////////////////////////////////
// packets carried between tiles on the processor chain
// and on the configuration chain
//////////////////////////////////////////////////////////////////////
package glb_packet_pkg;

    import glb_const_pkg::*;

    // processor write, one strobe bit per byte
    typedef struct packed {
        logic       wr_en;
        bank_strb_t wr_strb;
        glb_addr_t  wr_addr;
        bank_data_t wr_data;
    } proc_wr_t;

    // processor read request
    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } proc_rdrq_t;

    // processor read response, travels west
    typedef struct packed {
        bank_data_t rd_data;
        logic       rd_data_valid;
    } proc_rdrs_t;

    // everything that travels east on the processor chain
    typedef struct packed {
        proc_wr_t   wr;
        proc_rdrq_t rdrq;
    } proc_packet_t;

    // configuration request, one address for both directions
    typedef struct packed {
        logic      wr_en;
        logic      rd_en;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_req_t;

    typedef struct packed {
        cfg_data_t rd_data;
        logic      rd_data_valid;
    } cfg_rsp_t;

endpackage

// File: hw/glb_tile.sv
//////////////////////////////////////////////////////////////////////
// one global buffer tile: processor chain hop, address decode,
// write lock gating and westbound response merge
//////////////////////////////////////////////////////////////////////
module glb_tile
    import glb_const_pkg::*;
    import glb_packet_pkg::*;
#(
    parameter int tile_index = 0
) (
    input  logic         clk,
    input  logic         rst_n,

    // processor chain
    input  proc_packet_t proc_w2e_wsti,
    output proc_packet_t proc_w2e_esto,
    input  proc_rdrs_t   proc_e2w_esti,
    output proc_rdrs_t   proc_e2w_wsto,

    // configuration chain
    input  cfg_req_t     cfg_w2e_wsti,
    output cfg_req_t     cfg_w2e_esto,
    input  cfg_rsp_t     cfg_e2w_esti,
    output cfg_rsp_t     cfg_e2w_wsto
);

    localparam tile_id_t my_id   = tile_id_t'(tile_index);
    localparam bit       is_last = (tile_index == NUM_GLB_TILES - 1);

    proc_packet_t w2e_q;
    proc_rdrs_t   esti;
    proc_rdrs_t   wsto_q;
    cfg_rsp_t     cfg_esti;
    logic         wr_hit;
    logic         rd_hit;
    logic         rd_hit_q;
    logic         bank_wr_en;
    logic         wr_lock;
    bank_data_t   bank_rd_data;

    // nothing lies east of the last tile
    assign esti     = is_last ? proc_rdrs_t'('0) : proc_e2w_esti;
    assign cfg_esti = is_last ? cfg_rsp_t'('0) : cfg_e2w_esti;

    // tile field decode on the packet at our input
    assign wr_hit = proc_w2e_wsti.wr.wr_en
                 && proc_w2e_wsti.wr.wr_addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH] == my_id;
    assign rd_hit = proc_w2e_wsti.rdrq.rd_en
                 && proc_w2e_wsti.rdrq.rd_addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH] == my_id;

    // locked tile drops processor writes
    assign bank_wr_en = wr_hit && !wr_lock;

    // packets go on east unchanged, hit or not
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w2e_q.wr.wr_en   <= 1'b0;
            w2e_q.rdrq.rd_en <= 1'b0;
        end else begin
            w2e_q <= proc_w2e_wsti;
        end
    end

    // covers the bank's read cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_hit_q <= 1'b0;
        end else begin
            rd_hit_q <= rd_hit;
        end
    end

    // westbound hop, own bank data wins when present
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wsto_q.rd_data_valid <= 1'b0;
        end else if (rd_hit_q) begin
            wsto_q.rd_data       <= bank_rd_data;
            wsto_q.rd_data_valid <= 1'b1;
        end else begin
            wsto_q <= esti;
        end
    end

    assign proc_w2e_esto = w2e_q;
    assign proc_e2w_wsto = wsto_q;

    glb_bank glb_bank (
        .clk     (clk),
        .wr_en   (bank_wr_en),
        .wr_strb (proc_w2e_wsti.wr.wr_strb),
        .wr_addr (proc_w2e_wsti.wr.wr_addr[BANK_BYTE_OFFSET +: BANK_WORD_ADDR_WIDTH]),
        .wr_data (proc_w2e_wsti.wr.wr_data),
        .rd_en   (rd_hit),
        .rd_addr (proc_w2e_wsti.rdrq.rd_addr[BANK_BYTE_OFFSET +: BANK_WORD_ADDR_WIDTH]),
        .rd_data (bank_rd_data)
    );

    glb_tile_cfg #(
        .tile_index (tile_index)
    ) glb_tile_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_w2e_wsti (cfg_w2e_wsti),
        .cfg_w2e_esto (cfg_w2e_esto),
        .cfg_e2w_esti (cfg_esti),
        .cfg_e2w_wsto (cfg_e2w_wsto),
        .wr_lock      (wr_lock)
    );

    // reads spaced too closely would collide here and one response is lost
    a_rdrs_no_collision: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(rd_hit_q && esti.rd_data_valid)
    ) else $error("tile %0d: own and forwarded read responses collide", tile_index);

endmodule

// File: hw/glb_tile_cfg.sv
//////////////////////////////////////////////////////////////////////
// one hop of the configuration chain with the tile's
// control register and read-only tile id
//////////////////////////////////////////////////////////////////////
module glb_tile_cfg
    import glb_const_pkg::*;
    import glb_packet_pkg::*;
#(
    parameter int tile_index = 0
) (
    input  logic     clk,
    input  logic     rst_n,

    input  cfg_req_t cfg_w2e_wsti,
    output cfg_req_t cfg_w2e_esto,
    input  cfg_rsp_t cfg_e2w_esti,
    output cfg_rsp_t cfg_e2w_wsto,

    output logic     wr_lock
);

    localparam tile_id_t my_id = tile_id_t'(tile_index);

    cfg_req_t                     w2e_q;
    cfg_rsp_t                     own_q;
    cfg_rsp_t                     wsto_q;
    cfg_data_t                    ctrl_q;
    cfg_data_t                    rd_value;
    logic                         tile_hit;
    logic [CFG_REG_SEL_WIDTH-1:0] reg_sel;

    assign tile_hit = cfg_w2e_wsti.addr[AXI_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH] == my_id;
    assign reg_sel  = cfg_w2e_wsti.addr[CFG_REG_SEL_LSB +: CFG_REG_SEL_WIDTH];

    // unused register slots read back as zero
    always_comb begin
        case (reg_sel)
            CFG_REG_CTRL:    rd_value = ctrl_q;
            CFG_REG_TILE_ID: rd_value = cfg_data_t'(my_id);
            default:         rd_value = '0;
        endcase
    end

    // every request moves one tile east per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            w2e_q.wr_en <= 1'b0;
            w2e_q.rd_en <= 1'b0;
        end else begin
            w2e_q <= cfg_w2e_wsti;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (cfg_w2e_wsti.wr_en && tile_hit && reg_sel == CFG_REG_CTRL) begin
            ctrl_q <= cfg_w2e_wsti.data;
        end
    end

    // own answer waits one cycle, same as a bank read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own_q.rd_data_valid <= 1'b0;
        end else begin
            own_q.rd_data_valid <= cfg_w2e_wsti.rd_en && tile_hit;
            own_q.rd_data       <= rd_value;
        end
    end

    // westbound hop, own answer takes the slot when valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wsto_q.rd_data_valid <= 1'b0;
        end else if (own_q.rd_data_valid) begin
            wsto_q <= own_q;
        end else begin
            wsto_q <= cfg_e2w_esti;
        end
    end

    assign cfg_w2e_esto = w2e_q;
    assign cfg_e2w_wsto = wsto_q;
    assign wr_lock      = ctrl_q[CTRL_WR_LOCK_BIT];

    // one request is either a write or a read, all the way down the chain
    a_cfg_req_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(cfg_w2e_wsti.wr_en && cfg_w2e_wsti.rd_en)
    ) else $error("tile %0d: cfg request with wr_en and rd_en both set", tile_index);

endmodule

// File: hw/global_buffer.sv
//////////////////////////////////////////////////////////////////////
// global buffer top: packs the ports into packets and
// chains the tiles west to east
//////////////////////////////////////////////////////////////////////
module global_buffer
    import glb_const_pkg::*;
    import glb_packet_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // processor port
    input  logic       proc_wr_en,
    input  bank_strb_t proc_wr_strb,
    input  glb_addr_t  proc_wr_addr,
    input  bank_data_t proc_wr_data,
    input  logic       proc_rd_en,
    input  glb_addr_t  proc_rd_addr,
    output bank_data_t proc_rd_data,
    output logic       proc_rd_data_valid,

    // tile configuration port
    input  logic       cfg_wr_en,
    input  logic       cfg_rd_en,
    input  cfg_addr_t  cfg_addr,
    input  cfg_data_t  cfg_wr_data,
    output cfg_data_t  cfg_rd_data,
    output logic       cfg_rd_data_valid
);

    // entry i is the west side of tile i
    proc_packet_t proc_w2e [NUM_GLB_TILES+1];
    proc_rdrs_t   proc_e2w [NUM_GLB_TILES+1];
    cfg_req_t     cfg_w2e  [NUM_GLB_TILES+1];
    cfg_rsp_t     cfg_e2w  [NUM_GLB_TILES+1];

    assign proc_w2e[0].wr.wr_en     = proc_wr_en;
    assign proc_w2e[0].wr.wr_strb   = proc_wr_strb;
    assign proc_w2e[0].wr.wr_addr   = proc_wr_addr;
    assign proc_w2e[0].wr.wr_data   = proc_wr_data;
    assign proc_w2e[0].rdrq.rd_en   = proc_rd_en;
    assign proc_w2e[0].rdrq.rd_addr = proc_rd_addr;

    assign cfg_w2e[0].wr_en = cfg_wr_en;
    assign cfg_w2e[0].rd_en = cfg_rd_en;
    assign cfg_w2e[0].addr  = cfg_addr;
    assign cfg_w2e[0].data  = cfg_wr_data;

    // idle east edge, packets leaving the last tile stop here
    assign proc_e2w[NUM_GLB_TILES] = '0;
    assign cfg_e2w[NUM_GLB_TILES]  = '0;

    genvar i;
    generate
        for (i = 0; i < NUM_GLB_TILES; i++) begin : glb_tile_gen
            glb_tile #(
                .tile_index (i)
            ) glb_tile (
                .clk           (clk),
                .rst_n         (rst_n),
                .proc_w2e_wsti (proc_w2e[i]),
                .proc_w2e_esto (proc_w2e[i+1]),
                .proc_e2w_esti (proc_e2w[i+1]),
                .proc_e2w_wsto (proc_e2w[i]),
                .cfg_w2e_wsti  (cfg_w2e[i]),
                .cfg_w2e_esto  (cfg_w2e[i+1]),
                .cfg_e2w_esti  (cfg_e2w[i+1]),
                .cfg_e2w_wsto  (cfg_e2w[i])
            );
        end
    endgenerate

    // responses leave through tile 0
    assign proc_rd_data       = proc_e2w[0].rd_data;
    assign proc_rd_data_valid = proc_e2w[0].rd_data_valid;
    assign cfg_rd_data        = cfg_e2w[0].rd_data;
    assign cfg_rd_data_valid  = cfg_e2w[0].rd_data_valid;

endmodule

// File: project.f
+incdir+test
hw/glb_const_pkg.sv
hw/glb_packet_pkg.sv
hw/glb_bank.sv
hw/glb_tile_cfg.sv
hw/glb_tile.sv
hw/global_buffer.sv
test/tb_global_buffer.sv

// File: run_sim.sh
#!/bin/sh
# build and run the global buffer testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
    --top-module tb_global_buffer -o sim_glb \
    && ./obj_dir/sim_glb > sim.log 2>&1 \
    || echo "build or simulation stopped early"
cat sim.log 2>/dev/null
# the log decides pass or fail
grep -qx '\*\*\* PASSED \*\*\*' sim.log && echo "simulation result: pass" \
    || { echo "simulation result: fail"; exit 1; }

// File: test/glb_test_table.svh
//////////////////////////////////////////////////////////////////////
// directed operations and expected values for the global buffer
//////////////////////////////////////////////////////////////////////
`ifndef GLB_TEST_TABLE_SVH
`define GLB_TEST_TABLE_SVH

// for OP_IDLE the data column holds the cycle count
localparam int OP_IDLE = 0;
localparam int OP_PWR  = 1;
localparam int OP_PRD  = 2;
localparam int OP_CWR  = 3;
localparam int OP_CRD  = 4;

typedef struct {
    int         op;
    glb_addr_t  addr;
    bank_strb_t strb;
    bank_data_t data;
    bank_data_t expected;
    string      name;
} test_entry_t;

test_entry_t table_q [$];

task automatic add_entry(input int op, input glb_addr_t addr, input bank_strb_t strb,
                         input bank_data_t data, input bank_data_t expected,
                         input string name);
    test_entry_t e;
    e.op       = op;
    e.addr     = addr;
    e.strb     = strb;
    e.data     = data;
    e.expected = expected;
    e.name     = name;
    table_q.push_back(e);
endtask

task automatic load_table();
    // columns: op, address, strobe, data, expected, name
    add_entry(OP_IDLE, 12'h000, 8'h00, 64'd10, 64'd0, "idle after reset");
    add_entry(OP_CRD,  12'h000, 8'h00, 64'd0, 64'd0, "ctrl reset tile 0");
    add_entry(OP_CRD,  12'h040, 8'h00, 64'd0, 64'd0, "ctrl reset tile 1");
    add_entry(OP_CRD,  12'h080, 8'h00, 64'd0, 64'd0, "ctrl reset tile 2");
    add_entry(OP_CRD,  12'h0c0, 8'h00, 64'd0, 64'd0, "ctrl reset tile 3");
    // one full word per tile
    add_entry(OP_PWR,  12'h008, 8'hff, 64'h0123_4567_89ab_cdef, 64'd0, "write tile 0");
    add_entry(OP_PRD,  12'h008, 8'h00, 64'd0, 64'h0123_4567_89ab_cdef, "read tile 0");
    add_entry(OP_PWR,  12'h410, 8'hff, 64'h1111_2222_3333_4444, 64'd0, "write tile 1");
    add_entry(OP_PRD,  12'h410, 8'h00, 64'd0, 64'h1111_2222_3333_4444, "read tile 1");
    add_entry(OP_PWR,  12'h818, 8'hff, 64'h5555_6666_7777_8888, 64'd0, "write tile 2");
    add_entry(OP_PRD,  12'h818, 8'h00, 64'd0, 64'h5555_6666_7777_8888, "read tile 2");
    add_entry(OP_PWR,  12'hc20, 8'hff, 64'h9999_aaaa_bbbb_cccc, 64'd0, "write tile 3");
    add_entry(OP_PRD,  12'hc20, 8'h00, 64'd0, 64'h9999_aaaa_bbbb_cccc, "read tile 3");
    // low half only, upper bytes keep the old word
    add_entry(OP_PWR,  12'h430, 8'hff, 64'haaaa_bbbb_cccc_dddd, 64'd0, "strobe base");
    add_entry(OP_PWR,  12'h430, 8'h0f, 64'h1234_5678_9abc_def0, 64'd0, "strobe low half");
    add_entry(OP_PRD,  12'h430, 8'h00, 64'd0, 64'haaaa_bbbb_9abc_def0, "strobe merge");
    add_entry(OP_CRD,  12'h004, 8'h00, 64'd0, 64'd0, "tile id 0");
    add_entry(OP_CRD,  12'h044, 8'h00, 64'd0, 64'd1, "tile id 1");
    add_entry(OP_CRD,  12'h084, 8'h00, 64'd0, 64'd2, "tile id 2");
    add_entry(OP_CRD,  12'h0c4, 8'h00, 64'd0, 64'd3, "tile id 3");
    add_entry(OP_CWR,  12'h0c0, 8'h00, 64'd1, 64'd0, "ctrl set tile 3");
    add_entry(OP_CRD,  12'h0c0, 8'h00, 64'd0, 64'd1, "ctrl readback set");
    add_entry(OP_CWR,  12'h0c0, 8'h00, 64'd0, 64'd0, "ctrl clear tile 3");
    add_entry(OP_CRD,  12'h0c0, 8'h00, 64'd0, 64'd0, "ctrl readback clear");
    // tile 2 locked, tile 1 still writable
    add_entry(OP_PWR,  12'h840, 8'hff, 64'hdead_0000_0000_0001, 64'd0, "lock old word");
    add_entry(OP_CWR,  12'h080, 8'h00, 64'd1, 64'd0, "lock tile 2");
    add_entry(OP_PWR,  12'h840, 8'hff, 64'hdead_0000_0000_0002, 64'd0, "locked write");
    add_entry(OP_PWR,  12'h440, 8'hff, 64'hbeef_0000_0000_0003, 64'd0, "unlocked tile 1");
    add_entry(OP_PRD,  12'h840, 8'h00, 64'd0, 64'hdead_0000_0000_0001, "locked keeps");
    add_entry(OP_PRD,  12'h440, 8'h00, 64'd0, 64'hbeef_0000_0000_0003, "tile 1 lands");
    add_entry(OP_CRD,  12'h080, 8'h00, 64'd0, 64'd1, "lock readback");
    add_entry(OP_CWR,  12'h080, 8'h00, 64'd0, 64'd0, "unlock tile 2");
    add_entry(OP_PWR,  12'h840, 8'hff, 64'hdead_0000_0000_0004, 64'd0, "unlocked write");
    add_entry(OP_PRD,  12'h840, 8'h00, 64'd0, 64'hdead_0000_0000_0004, "unlocked lands");
endtask

`endif

// File: test/tb_global_buffer.sv
//////////////////////////////////////////////////////////////////////
// global buffer testbench with the directed table, random writes
// checked against a byte model, watchdog and summary
//////////////////////////////////////////////////////////////////////
module tb_global_buffer
    import glb_const_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int RAND_WRITES  = 48;
    localparam int RAND_WORDS   = 8;
    localparam int RAND_OPS     = RAND_WRITES + 2 * NUM_GLB_TILES * RAND_WORDS + 2;
    localparam int OP_CYCLES    = 2 * NUM_GLB_TILES + 6;
    localparam int RESP_LIMIT   = 4 * NUM_GLB_TILES + 8;

    logic       clk;
    logic       rst_n;
    logic       proc_wr_en;
    bank_strb_t proc_wr_strb;
    glb_addr_t  proc_wr_addr;
    bank_data_t proc_wr_data;
    logic       proc_rd_en;
    glb_addr_t  proc_rd_addr;
    bank_data_t proc_rd_data;
    logic       proc_rd_data_valid;
    logic       cfg_wr_en;
    logic       cfg_rd_en;
    cfg_addr_t  cfg_addr;
    cfg_data_t  cfg_wr_data;
    cfg_data_t  cfg_rd_data;
    logic       cfg_rd_data_valid;

    int errors;
    // byte model of all banks and of the lock bits
    bank_data_t               model_data  [NUM_GLB_TILES*BANK_DEPTH];
    logic [NUM_GLB_TILES-1:0] lock_model;

    `include "glb_test_table.svh"

    global_buffer UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_addr           (cfg_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic glb_addr_t bank_addr(input int tile, input int word);
        return {tile_id_t'(tile), bank_word_addr_t'(word), 3'b000};
    endfunction

    // one cycle per write, so consecutive calls run back to back
    task automatic write_bank_word(input glb_addr_t addr, input bank_strb_t strb,
                                   input bank_data_t data);
        int tile;
        int idx;
        tile = int'(addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH]);
        idx  = tile * BANK_DEPTH + int'(addr[BANK_BYTE_OFFSET +: BANK_WORD_ADDR_WIDTH]);
        proc_wr_en   = 1'b1;
        proc_wr_strb = strb;
        proc_wr_addr = addr;
        proc_wr_data = data;
        @(negedge clk);
        proc_wr_en = 1'b0;
        if (!lock_model[tile]) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    model_data[idx][b*BYTE_WIDTH +: BYTE_WIDTH] =
                        data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    endtask

    task automatic write_register(input cfg_addr_t addr, input cfg_data_t data);
        cfg_wr_en   = 1'b1;
        cfg_addr    = addr;
        cfg_wr_data = data;
        @(negedge clk);
        cfg_wr_en = 1'b0;
        if (addr[CFG_REG_SEL_LSB +: CFG_REG_SEL_WIDTH] == CFG_REG_CTRL) begin
            lock_model[addr[AXI_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH]] = data[CTRL_WR_LOCK_BIT];
        end
    endtask

    // counts rising edges until the valid is seen at a falling edge
    task automatic await_response(input bit from_cfg, input string name,
                                  output bit seen, output int lat);
        seen = 1'b0;
        lat  = 0;
        while (!seen && lat < RESP_LIMIT) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            proc_rd_en = 1'b0;
            cfg_rd_en  = 1'b0;
            seen = from_cfg ? cfg_rd_data_valid : proc_rd_data_valid;
        end
        if (!seen) begin
            errors++;
            $display("ERROR: %s got no read response within %0d cycles", name, RESP_LIMIT);
        end
    endtask

    task automatic read_bank_word(input glb_addr_t addr, input string name,
                                  output bank_data_t data);
        int tile;
        int lat;
        bit seen;
        tile = int'(addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH]);
        proc_rd_en   = 1'b1;
        proc_rd_addr = addr;
        await_response(1'b0, name, seen, lat);
        data = proc_rd_data;
        if (seen) check_value({name, " latency"}, 64'(2*tile + 2), 64'(lat));
    endtask

    task automatic read_register(input cfg_addr_t addr, input string name,
                                 output cfg_data_t data);
        int tile;
        int lat;
        bit seen;
        tile = int'(addr[AXI_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH]);
        cfg_rd_en = 1'b1;
        cfg_addr  = addr;
        await_response(1'b1, name, seen, lat);
        data = cfg_rd_data;
        if (seen) check_value({name, " latency"}, 64'(2*tile + 2), 64'(lat));
    endtask

    task automatic watch_idle(input int cycles, input string name);
        repeat (cycles) begin
            @(negedge clk);
            check_value({name, " proc valid"}, 64'd0, 64'(proc_rd_data_valid));
            check_value({name, " cfg valid"}, 64'd0, 64'(cfg_rd_data_valid));
        end
    endtask

    task automatic apply_entry(input test_entry_t e);
        bank_data_t rdata;
        cfg_data_t  cdata;
        case (e.op)
            OP_IDLE: watch_idle(int'(e.data), e.name);
            OP_PWR:  write_bank_word(e.addr, e.strb, e.data);
            OP_PRD: begin
                read_bank_word(e.addr, e.name, rdata);
                check_value(e.name, e.expected, rdata);
            end
            OP_CWR:  write_register(cfg_addr_t'(e.addr), cfg_data_t'(e.data));
            OP_CRD: begin
                read_register(cfg_addr_t'(e.addr), e.name, cdata);
                check_value(e.name, e.expected, 64'(cdata));
            end
            default: begin
                errors++;
                $display("ERROR: table entry %s has an unknown operation", e.name);
            end
        endcase
    endtask

    task automatic run_random_phase();
        int         tile;
        int         word;
        int         lock_tile;
        int         idx;
        string      name;
        bank_data_t rdata;
        // every word starts fully written so each byte has a known value
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            for (int w = 0; w < RAND_WORDS; w++) begin
                write_bank_word(bank_addr(t, w), '1, {$urandom, $urandom});
            end
        end
        lock_tile = int'($urandom % NUM_GLB_TILES);
        write_register({tile_id_t'(lock_tile), 6'h00}, 32'd1);
        repeat (RAND_WRITES) begin
            tile = int'($urandom % NUM_GLB_TILES);
            word = int'($urandom % RAND_WORDS);
            write_bank_word(bank_addr(tile, word), bank_strb_t'($urandom), {$urandom, $urandom});
        end
        write_register({tile_id_t'(lock_tile), 6'h00}, 32'd0);
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            for (int w = 0; w < RAND_WORDS; w++) begin
                idx  = t * BANK_DEPTH + w;
                name = $sformatf("random tile %0d word %0d", t, w);
                read_bank_word(bank_addr(t, w), name, rdata);
                check_value(name, model_data[idx], rdata);
            end
        end
    endtask

    initial begin
        errors       = 0;
        lock_model   = '0;
        rst_n        = 1'b0;
        proc_wr_en   = 1'b0;
        proc_wr_strb = '0;
        proc_wr_addr = '0;
        proc_wr_data = '0;
        proc_rd_en   = 1'b0;
        proc_rd_addr = '0;
        cfg_wr_en    = 1'b0;
        cfg_rd_en    = 1'b0;
        cfg_addr     = '0;
        cfg_wr_data  = '0;
        foreach (model_data[i]) begin
            model_data[i] = '0;
        end
        void'($urandom(32'h84ed));
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        run_random_phase();
        watch_idle(4, "idle at end");
        $display("run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // the table is loaded at time zero and its size is known after one step
    initial begin
        #1;
        #((table_q.size() + RAND_OPS) * OP_CYCLES * CLK_PERIOD + 500);
        $display("watchdog: run did not finish within its time budget");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
